// File: source/i2c_reg_pkg.sv
package i2c_reg_pkg;

	// host side request, setup phase has penable low
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register map
	localparam logic [7:0] REG_ADR    = 8'h00; // 7-bit target address
	localparam logic [7:0] REG_NBY    = 8'h04; // byte count minus one
	localparam logic [7:0] REG_TDR    = 8'h08;
	localparam logic [7:0] REG_RDR    = 8'h0C; // read only
	localparam logic [7:0] REG_CMD    = 8'h10; // write queues, bit 0 = read
	localparam logic [7:0] REG_STATUS = 8'h14;

	// STATUS fields
	localparam int STATUS_BUSY    = 0;
	localparam int STATUS_NACK    = 1;
	localparam int STATUS_DONE    = 2; // sticky, write 1 clears
	localparam int STATUS_LVL_LSB = 4;
	localparam int STATUS_LVL_MSB = 7;

endpackage

// File: source/i2c_xfer_pkg.sv
package i2c_xfer_pkg;

	// word view for the host, byte view for the bit engine
	// byte 0 sits in bits 7:0 and goes on the bus first
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] bytes;
	} i2c_data_u;

	typedef struct packed {
		logic       rd;
		logic [6:0] addr;
		logic [1:0] nby;  // bytes minus one
		i2c_data_u  data;
	} i2c_cmd_t;

	// valid is a single cycle pulse per finished transfer
	typedef struct packed {
		logic      valid;
		logic      nack;
		i2c_data_u rdata;
	} i2c_res_t;

endpackage

// File: source/i2c_apb_regs.sv
`timescale 1ns/1ps

module i2c_apb_regs import i2c_reg_pkg::*, i2c_xfer_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  apb_req_t   apb_req_i,
	output apb_rsp_t   apb_rsp_o,
	output i2c_cmd_t   cmd_o,
	output logic       push_o,
	input  logic       fifo_full_i,
	input  logic [3:0] fifo_level_i,
	input  i2c_res_t   res_i,
	input  logic       busy_i,
	output logic       irq_o
);

	logic [6:0] adr_q;
	logic [1:0] nby_q;
	i2c_data_u  tdr_q;
	i2c_data_u  rdr_q;
	logic       nack_q;
	logic       done_q;

	logic        access;
	logic        wr_en;
	logic        mapped;
	logic        cmd_wr;
	logic [31:0] status_word;
	logic [31:0] rd_word;

	assign access = apb_req_i.psel & apb_req_i.penable;
	assign wr_en  = access & apb_req_i.pwrite;
	assign cmd_wr = wr_en & (apb_req_i.paddr == REG_CMD);

	always_comb begin
		case (apb_req_i.paddr)
			REG_ADR, REG_NBY, REG_TDR, REG_RDR, REG_CMD, REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// a full FIFO drops the command and flags the access
	assign push_o = cmd_wr & ~fifo_full_i;

	assign cmd_o.rd   = apb_req_i.pwdata[0];
	assign cmd_o.addr = adr_q;
	assign cmd_o.nby  = nby_q;
	assign cmd_o.data = tdr_q;

	always_comb begin
		status_word = '0;
		status_word[STATUS_BUSY] = busy_i;
		status_word[STATUS_NACK] = nack_q;
		status_word[STATUS_DONE] = done_q;
		status_word[STATUS_LVL_MSB:STATUS_LVL_LSB] = fifo_level_i;
	end

	always_comb begin
		rd_word = '0;
		case (apb_req_i.paddr)
			REG_ADR:    rd_word[6:0] = adr_q;
			REG_NBY:    rd_word[1:0] = nby_q;
			REG_TDR:    rd_word = tdr_q.word;
			REG_RDR:    rd_word = rdr_q.word;
			REG_STATUS: rd_word = status_word;
			default:    rd_word = '0; // CMD reads back as zero
		endcase
	end

	// no wait states
	assign apb_rsp_o.prdata  = (access & ~apb_req_i.pwrite) ? rd_word : '0;
	assign apb_rsp_o.pready  = access;
	assign apb_rsp_o.pslverr = access & (~mapped | (cmd_wr & fifo_full_i));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			adr_q     <= '0;
			nby_q     <= '0;
			tdr_q     <= '0;
			rdr_q     <= '0;
			nack_q    <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			if (wr_en) begin
				case (apb_req_i.paddr)
					REG_ADR: adr_q <= apb_req_i.pwdata[6:0];
					REG_NBY: nby_q <= apb_req_i.pwdata[1:0];
					REG_TDR: tdr_q.word <= apb_req_i.pwdata;
					REG_STATUS: begin
						if (apb_req_i.pwdata[STATUS_DONE])
							done_q <= 1'b0;
					end
					default: ;
				endcase
			end
			// a finishing transfer wins over a clear in the same cycle
			if (res_i.valid) begin
				rdr_q  <= res_i.rdata; // zero for writes and NACKs
				nack_q <= res_i.nack;
				done_q <= 1'b1;
			end
		end
	end

	assign irq_o = done_q;

endmodule

// File: source/i2c_cmd_fifo.sv
`timescale 1ns/1ps

module i2c_cmd_fifo import i2c_xfer_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       push_i,
	input  i2c_cmd_t   cmd_i,
	input  logic       pop_i,
	output i2c_cmd_t   cmd_o,
	output logic       empty_o,
	output logic       full_o,
	output logic [3:0] level_o
);

	localparam int PW = $clog2(FIFO_DEPTH);

	i2c_cmd_t      mem [FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [3:0]    count;
	logic          do_push;
	logic          do_pop;

	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= cmd_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 4'd1;
				2'b01:   count <= count - 4'd1;
				default: count <= count;
			endcase
		end
	end

	assign cmd_o   = mem[rd_ptr]; // head always visible
	assign empty_o = (count == 4'd0);
	assign full_o  = (count == 4'(FIFO_DEPTH));
	assign level_o = count;

endmodule

// File: source/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine import i2c_xfer_pkg::*; #(
	parameter int CLK_DIV = 4
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  i2c_cmd_t cmd_i,
	input  logic     empty_i,
	output logic     pop_o,
	output i2c_res_t res_o,
	output logic     busy_o,
	output logic     scl_o,
	output logic     sda_oe_o,
	input  logic     sda_i
);

	localparam int DW = $clog2(CLK_DIV);

	typedef enum logic [2:0] {
		S_IDLE, S_START, S_ADDR, S_ACK, S_WDATA, S_RDATA, S_DACK, S_STOP
	} state_t;

	state_t        state;
	logic [DW-1:0] div_cnt;
	logic [1:0]    phase;    // quarter of the current bit
	logic [2:0]    bit_cnt;  // MSB first
	logic [1:0]    byte_idx;
	logic          res_valid;

	i2c_cmd_t  cmd_q;
	i2c_data_u rx_q;
	logic      nack_q;
	logic      res_nack;
	i2c_data_u res_data;

	logic       tick;
	logic       sample;
	logic       bit_end;
	logic [7:0] addr_byte;

	assign tick      = (div_cnt == DW'(CLK_DIV - 1));
	assign sample    = tick & (phase == 2'd1); // middle of SCL high
	assign bit_end   = tick & (phase == 2'd3);
	assign addr_byte = {cmd_q.addr, cmd_q.rd};

	assign pop_o  = (state == S_IDLE) & ~empty_i;
	assign busy_o = (state != S_IDLE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= S_IDLE;
			div_cnt   <= '0;
			phase     <= '0;
			bit_cnt   <= '0;
			byte_idx  <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (state == S_IDLE) begin
				div_cnt <= '0;
				phase   <= '0;
				if (!empty_i)
					state <= S_START;
			end else if (tick) begin
				div_cnt <= '0;
				phase   <= phase + 2'd1;
				if (bit_end) begin
					case (state)
						S_START: begin
							bit_cnt <= 3'd7;
							state   <= S_ADDR;
						end
						S_ADDR: begin
							if (bit_cnt == 3'd0)
								state <= S_ACK;
							else
								bit_cnt <= bit_cnt - 3'd1;
						end
						S_ACK: begin
							bit_cnt  <= 3'd7;
							byte_idx <= 2'd0;
							if (nack_q)
								state <= S_STOP;
							else
								state <= cmd_q.rd ? S_RDATA : S_WDATA;
						end
						S_WDATA, S_RDATA: begin
							if (bit_cnt == 3'd0)
								state <= S_DACK;
							else
								bit_cnt <= bit_cnt - 3'd1;
						end
						S_DACK: begin
							if (nack_q || byte_idx == cmd_q.nby) begin
								state <= S_STOP;
							end else begin
								byte_idx <= byte_idx + 2'd1;
								bit_cnt  <= 3'd7;
								state    <= cmd_q.rd ? S_RDATA : S_WDATA;
							end
						end
						S_STOP: begin
							state     <= S_IDLE;
							res_valid <= 1'b1;
						end
						default: state <= S_IDLE;
					endcase
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// datapath, loaded on accept
	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			cmd_q       <= cmd_i;
			rx_q.word   <= '0; // unread lanes stay zero
			nack_q      <= 1'b0;
		end else if (sample) begin
			if (state == S_ACK || (state == S_DACK && !cmd_q.rd))
				nack_q <= sda_i; // released line means NACK
			if (state == S_RDATA)
				rx_q.bytes[byte_idx][bit_cnt] <= sda_i;
		end
		if (bit_end && state == S_STOP) begin
			res_nack      <= nack_q;
			res_data.word <= nack_q ? 32'd0 : rx_q.word;
		end
	end

	assign res_o.valid = res_valid;
	assign res_o.nack  = res_nack;
	assign res_o.rdata = res_data;

	// line levels per quarter, data moves only while SCL is low
	always_comb begin
		case (state)
			S_IDLE: begin
				scl_o    = 1'b1;
				sda_oe_o = 1'b0;
			end
			S_START: begin
				scl_o    = (phase != 2'd3);
				sda_oe_o = (phase != 2'd0); // falls while SCL high
			end
			S_STOP: begin
				scl_o    = (phase != 2'd0);
				sda_oe_o = (phase < 2'd2);  // rises while SCL high
			end
			S_ADDR: begin
				scl_o    = (phase == 2'd1) || (phase == 2'd2);
				sda_oe_o = ~addr_byte[bit_cnt];
			end
			S_WDATA: begin
				scl_o    = (phase == 2'd1) || (phase == 2'd2);
				sda_oe_o = ~cmd_q.data.bytes[byte_idx][bit_cnt];
			end
			S_DACK: begin
				scl_o    = (phase == 2'd1) || (phase == 2'd2);
				sda_oe_o = cmd_q.rd & (byte_idx != cmd_q.nby); // NACK the last read byte
			end
			default: begin
				scl_o    = (phase == 2'd1) || (phase == 2'd2);
				sda_oe_o = 1'b0;
			end
		endcase
	end

endmodule

// File: source/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top import i2c_reg_pkg::*, i2c_xfer_pkg::*; #(
	parameter int CLK_DIV    = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  apb_req_t apb_req_i,
	output apb_rsp_t apb_rsp_o,
	output logic     scl_o,
	output logic     sda_oe_o,
	input  logic     sda_i,
	output logic     irq_o
);

	i2c_cmd_t   new_cmd;
	i2c_cmd_t   head_cmd;
	i2c_res_t   result;
	logic       push;
	logic       pop;
	logic       fifo_full;
	logic       fifo_empty;
	logic [3:0] fifo_level;
	logic       busy;

	i2c_apb_regs i_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.apb_req_i    (apb_req_i),
		.apb_rsp_o    (apb_rsp_o),
		.cmd_o        (new_cmd),
		.push_o       (push),
		.fifo_full_i  (fifo_full),
		.fifo_level_i (fifo_level),
		.res_i        (result),
		.busy_i       (busy),
		.irq_o        (irq_o)
	);

	i2c_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (push),
		.cmd_i   (new_cmd),
		.pop_i   (pop),
		.cmd_o   (head_cmd),
		.empty_o (fifo_empty),
		.full_o  (fifo_full),
		.level_o (fifo_level)
	);

	i2c_bit_engine #(
		.CLK_DIV (CLK_DIV)
	) i_engine (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.cmd_i    (head_cmd),
		.empty_i  (fifo_empty),
		.pop_o    (pop),
		.res_o    (result),
		.busy_o   (busy),
		.scl_o    (scl_o),
		.sda_oe_o (sda_oe_o),
		.sda_i    (sda_i)
	);

endmodule

// File: verif/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h52
) (
	input  logic scl_i,
	input  logic sda_i,  // resolved line
	output logic sda_oe_o
);

	logic [7:0] mem [4];
	logic       active;
	logic       addr_phase;
	logic       is_read;
	logic       master_ack;
	logic [7:0] shift;
	logic [3:0] bit_n;    // 8 is the ACK slot
	logic [1:0] byte_idx;

	initial begin
		for (int i = 0; i < 4; i++)
			mem[i] = 8'h5a ^ (8'(i) * 8'h3b);
		active     = 1'b0;
		addr_phase = 1'b0;
		is_read    = 1'b0;
		master_ack = 1'b0;
		shift      = '0;
		bit_n      = '0;
		byte_idx   = '0;
		sda_oe_o   = 1'b0;
	end

	// start condition
	always @(negedge sda_i) begin
		if (scl_i === 1'b1) begin
			active     = 1'b1;
			addr_phase = 1'b1;
			bit_n      = 4'hf; // the start's own SCL fall wraps this to bit 0
			byte_idx   = '0;
			sda_oe_o   = 1'b0;
		end
	end

	// stop condition
	always @(posedge sda_i) begin
		if (scl_i === 1'b1) begin
			active   = 1'b0;
			sda_oe_o = 1'b0;
		end
	end

	always @(posedge scl_i) begin
		if (active) begin
			if (bit_n < 4'd8)
				shift = {shift[6:0], sda_i};
			else
				master_ack = ~sda_i;
		end
	end

	// the line only moves while SCL is low
	always @(negedge scl_i) begin
		if (active) begin
			if (bit_n == 4'd7) begin
				bit_n = 4'd8;
				if (addr_phase) begin
					if (shift[7:1] == ADDR) begin
						is_read  = shift[0];
						sda_oe_o = 1'b1;
					end else begin
						active   = 1'b0; // not ours
						sda_oe_o = 1'b0;
					end
				end else if (!is_read) begin
					mem[byte_idx] = shift;
					byte_idx      = byte_idx + 2'd1;
					sda_oe_o      = 1'b1;
				end else begin
					sda_oe_o = 1'b0; // master acks
				end
			end else if (bit_n == 4'd8) begin
				bit_n = '0;
				if (addr_phase) begin
					addr_phase = 1'b0;
					sda_oe_o   = is_read & ~mem[byte_idx][7];
				end else if (is_read && master_ack) begin
					byte_idx = byte_idx + 2'd1;
					sda_oe_o = ~mem[byte_idx][7];
				end else begin
					sda_oe_o = 1'b0;
				end
			end else begin
				bit_n    = bit_n + 4'd1;
				sda_oe_o = is_read & ~addr_phase & ~mem[byte_idx][3'd7 - bit_n[2:0]];
			end
		end
	end

endmodule

// File: verif/i2c_master_assertions.sv
`timescale 1ns/1ps

module i2c_master_assertions import i2c_reg_pkg::*; (
	input logic       clk_i,
	input logic       rst_i,
	input apb_req_t   apb_req_i,
	input apb_rsp_t   apb_rsp_o,
	input logic       scl_o,
	input logic       sda_i,
	input logic       irq_o,
	input logic [2:0] eng_state_i
);

	localparam logic [2:0] ST_START = 3'd1;
	localparam logic [2:0] ST_STOP  = 3'd7;

	pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
		(apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_o.pready)
		else $error("pready low in APB access phase");

	// only start and stop may move SDA under a high SCL
	sda_stable_scl_high: assert property (@(posedge clk_i) disable iff (rst_i)
		(scl_o && $past(scl_o) && (sda_i != $past(sda_i)))
			|-> (eng_state_i == ST_START || eng_state_i == ST_STOP))
		else $error("SDA changed while SCL high outside start or stop");

	irq_low_after_reset: assert property (@(posedge clk_i) $past(rst_i) |-> !irq_o)
		else $error("irq high right after reset");

endmodule

bind i2c_master_top i2c_master_assertions i_assertions (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.apb_req_i   (apb_req_i),
	.apb_rsp_o   (apb_rsp_o),
	.scl_o       (scl_o),
	.sda_i       (sda_i),
	.irq_o       (irq_o),
	.eng_state_i (i_engine.state)
);

// File: verif/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master import i2c_reg_pkg::*, i2c_xfer_pkg::*; ();

	localparam int FIFO_DEPTH = 4;
	localparam int NROWS      = 10;

	typedef struct packed {
		logic       rd;
		logic [6:0] addr;
		logic [1:0] nby;
		i2c_data_u  wdata;
		logic       exp_nack;
		i2c_data_u  exp_rdata;
	} row_t;

	logic     clk_i;
	logic     rst_i;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     scl;
	logic     dut_oe;
	logic     slv_oe;
	logic     irq;
	wire      sda_line = ~(dut_oe | slv_oe); // open drain with pull-up

	row_t       rows [NROWS];
	logic [7:0] shadow [4];
	int         seed = 87021;
	int         errors;
	int         test_errors;
	int         tests_failed;

	i2c_master_top #(
		.CLK_DIV    (4),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_dut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.apb_req_i (apb_req),
		.apb_rsp_o (apb_rsp),
		.scl_o     (scl),
		.sda_oe_o  (dut_oe),
		.sda_i     (sda_line),
		.irq_o     (irq)
	);

	i2c_slave_model #(.ADDR(7'h52)) i_slave (
		.scl_i    (scl),
		.sda_i    (sda_line),
		.sda_oe_o (slv_oe)
	);

	always #5 clk_i = ~clk_i;

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		apb_req_t r;
		r = '0;
		r.psel   = 1'b1;
		r.pwrite = wr;
		r.paddr  = addr;
		r.pwdata = wdata;
		@(posedge clk_i);
		apb_req <= r;
		r.penable = 1'b1;
		@(posedge clk_i);
		apb_req <= r;
		@(negedge clk_i); // response settled in access phase
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk_i);
		apb_req <= '0;
	endtask

	task automatic compare_status(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_data(input string name, input i2c_data_u got, input i2c_data_u exp);
		if (got.word !== exp.word) begin
			$display("ERROR %s: got %h expected %h", name, got.word, exp.word);
			test_errors++;
		end
	endtask

	task automatic compare_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        e;
		apb_xfer(1'b1, addr, data, rd, e);
		compare_err("pslverr", e, 1'b0);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		logic        e;
		int          n;
		st = '0;
		n  = 0;
		while (!st[STATUS_DONE] && n < 2000) begin
			apb_xfer(1'b0, REG_STATUS, 32'd0, st, e);
			n++;
		end
		if (!st[STATUS_DONE]) begin
			$display("timeout while waiting for the done flag");
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic wait_drained();
		logic [31:0] st;
		logic        e;
		int          n;
		st = 32'h1;
		n  = 0;
		while ((st[STATUS_BUSY] || st[STATUS_LVL_MSB:STATUS_LVL_LSB] != 4'd0) && n < 5000) begin
			apb_xfer(1'b0, REG_STATUS, 32'd0, st, e);
			n++;
		end
		if (st[STATUS_BUSY] || st[STATUS_LVL_MSB:STATUS_LVL_LSB] != 4'd0) begin
			$display("timeout while waiting for the command queue to drain");
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic clear_done();
		write_reg(REG_STATUS, 32'h1 << STATUS_DONE);
		@(negedge clk_i);
		compare_err("irq_o", irq, 1'b0);
	endtask

	// rows follow the transfer rules, shadow tracks what the target should hold
	task automatic build_table();
		for (int i = 0; i < 4; i++)
			shadow[i] = 8'h5a ^ (8'(i) * 8'h3b);
		for (int i = 0; i < NROWS; i++) begin
			rows[i] = '0;
			rows[i].wdata.word = $random(seed);
			rows[i].addr = (i < 8) ? 7'h52 : 7'h13;
			rows[i].rd   = (i >= 4 && i < 8) || i == 9;
			rows[i].nby  = (i < 8) ? 2'(i % 4) : 2'(i - 7);
			rows[i].exp_nack = (i >= 8);
			if (!rows[i].exp_nack) begin
				for (int j = 0; j <= int'(rows[i].nby); j++) begin
					if (rows[i].rd)
						rows[i].exp_rdata.bytes[j] = shadow[j];
					else
						shadow[j] = rows[i].wdata.bytes[j];
				end
			end
		end
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] rd;
		logic        e;
		i2c_data_u   got;
		i2c_data_u   exp;
		logic [31:0] exp_st;
		write_reg(REG_ADR, {25'd0, r.addr});
		write_reg(REG_NBY, {30'd0, r.nby});
		write_reg(REG_TDR, r.wdata.word);
		write_reg(REG_CMD, {31'd0, r.rd});
		wait_done();
		apb_xfer(1'b0, REG_STATUS, 32'd0, rd, e);
		exp_st = '0;
		exp_st[STATUS_NACK] = r.exp_nack;
		exp_st[STATUS_DONE] = 1'b1;
		compare_status("STATUS", rd, exp_st);
		apb_xfer(1'b0, REG_RDR, 32'd0, rd, e);
		got.word = rd;
		compare_data("RDR", got, r.exp_rdata);
		compare_err("irq_o", irq, 1'b1);
		if (!r.rd && !r.exp_nack) begin
			got.word = '0;
			exp.word = '0;
			for (int j = 0; j <= int'(r.nby); j++) begin
				got.bytes[j] = i_slave.mem[j];
				exp.bytes[j] = r.wdata.bytes[j];
			end
			compare_data("slave_mem", got, exp);
		end
		clear_done();
	endtask

	task automatic run_burst();
		logic [31:0] rd;
		logic        e;
		write_reg(REG_ADR, 32'h52);
		write_reg(REG_NBY, 32'h0);
		for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
			apb_xfer(1'b1, REG_CMD, 32'h0, rd, e);
			compare_err("pslverr", e, k > FIFO_DEPTH); // one slot sits in the engine
			apb_xfer(1'b0, REG_STATUS, 32'd0, rd, e);
			if (rd[STATUS_LVL_MSB:STATUS_LVL_LSB] > 4'(FIFO_DEPTH)) begin
				$display("FIFO level %0d is above the depth", rd[STATUS_LVL_MSB:STATUS_LVL_LSB]);
				test_errors++;
			end
		end
		wait_drained();
		clear_done();
	endtask

	task automatic run_regs();
		logic [31:0] rd;
		logic [31:0] tdr;
		logic        e;
		i2c_data_u   got;
		i2c_data_u   exp;
		tdr = $random(seed);
		write_reg(REG_ADR, 32'h2a);
		write_reg(REG_NBY, 32'h2);
		write_reg(REG_TDR, tdr);
		apb_xfer(1'b0, REG_ADR, 32'd0, rd, e);
		compare_status("ADR", rd, 32'h2a);
		apb_xfer(1'b0, REG_NBY, 32'd0, rd, e);
		compare_status("NBY", rd, 32'h2);
		apb_xfer(1'b0, REG_TDR, 32'd0, rd, e);
		got.word = rd;
		exp.word = tdr;
		compare_data("TDR", got, exp);
		apb_xfer(1'b1, 8'h20, 32'h1, rd, e);
		compare_err("pslverr", e, 1'b1);
		apb_xfer(1'b0, 8'h24, 32'd0, rd, e);
		compare_err("pslverr", e, 1'b1);
	endtask

	task automatic report(input int num, input string what);
		if (test_errors == 0) begin
			$display("test %0d %s: ok", num, what);
		end else begin
			$display("test %0d %s: %0d errors", num, what, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		clk_i        = 1'b0;
		rst_i        = 1'b1;
		apb_req      = '0;
		errors       = 0;
		test_errors  = 0;
		tests_failed = 0;
		build_table();
		repeat (8) @(posedge clk_i);
		rst_i <= 1'b0;
		for (int i = 0; i < NROWS; i++) begin
			run_row(rows[i]);
			report(i + 1, rows[i].rd ? "read" : "write");
		end
		run_burst();
		report(NROWS + 1, "burst");
		run_regs();
		report(NROWS + 2, "registers");
		$display("tests %0d, failed %0d, errors %0d", NROWS + 2, tests_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: i2c_master.f
source/i2c_reg_pkg.sv
source/i2c_xfer_pkg.sv
source/i2c_apb_regs.sv
source/i2c_cmd_fifo.sv
source/i2c_bit_engine.sv
source/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/i2c_master_assertions.sv
verif/tb_i2c_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f i2c_master.f \
	--top-module tb_i2c_master \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	exit 0
fi
exit 1
